// ==== filelist.f ====
+incdir+.
spio_pkg.sv
spio_flit_if.sv
spio_flit_capture.sv
spio_frame_checker.sv
spio_pkt_shifter.sv
spio_pkt_out.sv
spio_link_receiver.sv
tb_spio_link_receiver.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the link receiver testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_spio_link_receiver

./obj_dir/Vtb_spio_link_receiver | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
  echo "run_sim: PASS"
  exit 0
fi

echo "run_sim: FAIL"
exit 1

// ==== spio_cfg.svh ====
`ifndef SPIO_CFG_SVH
`define SPIO_CFG_SVH

// --------------------
// link symbol widths
`define SPIO_SYM_BITS 7      // 2-of-7 wires
`define SPIO_NIB_BITS 4      // payload bits per data symbol

// --------------------
// packet geometry
`define SPIO_PKT_BITS 72     // long packet, header + key + payload
`define SPIO_SPKT_FLTS 10    // data flits, short packet
`define SPIO_LPKT_FLTS 18    // data flits, long packet
`define SPIO_SHORT_SHIFT 32  // unused top of buffer for short packets

// clock domain crossing
`define SPIO_SYNC_STAGES 2

`endif

// ==== spio_flit_capture.sv ====
`include "spio_cfg.svh"

module spio_flit_capture (
  input  logic            CLK_IN,
  input  logic            RESET_IN,
  input  spio_pkg::code_t link_data,
  output logic            link_ack,
  spio_flit_if.src        flit
);

  spio_pkg::code_t sync_q [`SPIO_SYNC_STAGES];  // link synchronizer chain
  spio_pkg::code_t link_sync;                    // last sync stage
  spio_pkg::code_t last_q;                       // nrz value of last accepted symbol
  spio_pkg::code_t rtz_code;                     // wires changed since then
  logic            start_q;                      // first cycle out of reset
  logic            accept;                       // take symbol this cycle

  // --------------------
  // synchronizer
  always_ff @(posedge CLK_IN) begin
    sync_q[0] <= link_data;
    for (int i = 1; i < `SPIO_SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  assign link_sync = sync_q[`SPIO_SYNC_STAGES-1];

  // nrz to rtz, changed wires only
  assign rtz_code = link_sync ^ last_q;

  // new symbol with room downstream
  // nothing is taken in the start-up cycle
  assign accept = !start_q && spio_pkg::is_new_sym(rtz_code) && flit.rdy;

  // --------------------
  // ack and strobe
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      start_q  <= 1'b1;
      link_ack <= 1'b0;
      flit.vld <= 1'b0;
    end else begin
      start_q  <= 1'b0;
      flit.vld <= accept;  // one strobe per accepted symbol
      if (start_q || accept) begin
        link_ack <= ~link_ack;  // start-up ack, then one per symbol
      end
    end
  end

  // reference value and symbol payload
  always_ff @(posedge CLK_IN) begin
    if (start_q || accept) begin
      last_q <= link_sync;  // initial idle value on start-up
    end
    if (accept) begin
      flit.kind <= spio_pkg::classify(rtz_code);
      flit.nib  <= spio_pkg::decode(rtz_code);
    end
  end

  // --------------------
  // the output stage may not refuse a symbol that was already strobed
  a_vld_while_rdy : assert property (
    @(posedge CLK_IN) disable iff (RESET_IN)
    flit.vld |-> flit.rdy
  ) else $error("symbol strobed while output stage busy");

endmodule

// ==== spio_flit_if.sv ====
// accepted link symbols, capture to frame checker and shifter
interface spio_flit_if;

  logic                vld;   // one-cycle strobe per accepted symbol
  spio_pkg::sym_kind_t kind;
  spio_pkg::nib_t      nib;   // decoded payload, data symbols only
  logic                rdy;   // output stage can take more symbols

  modport src (
    output vld,
    output kind,
    output nib,
    input  rdy
  );

  modport sink_ctl (
    input vld,
    input kind,
    input nib,
    input rdy
  );

  modport sink_dat (
    input vld,
    input kind,
    input nib
  );

endinterface

// ==== spio_frame_checker.sv ====
`include "spio_cfg.svh"

module spio_frame_checker (
  input  logic          CLK_IN,
  input  logic          RESET_IN,
  spio_flit_if.sink_ctl flit,
  output logic          pkt_done,
  output logic          pkt_long,
  output logic          flt_err,
  output logic          frm_err
);

  typedef enum logic [1:0] {
    st_idle,  // waiting for first data flit
    st_recv,  // counting data flits
    st_drop   // after a bad symbol, until eop
  } state_t;

  state_t              state_q;
  spio_pkg::flit_cnt_t cnt_q;    // data flits so far
  spio_pkg::flit_cnt_t exp_cnt;  // data flits this packet needs
  logic                is_data;
  logic                is_eop;
  logic                is_bad;

  assign is_data = flit.vld && (flit.kind == spio_pkg::sym_data);
  assign is_eop  = flit.vld && (flit.kind == spio_pkg::sym_eop);
  assign is_bad  = flit.vld && (flit.kind == spio_pkg::sym_bad);

  assign exp_cnt = pkt_long ? 5'(`SPIO_LPKT_FLTS) : 5'(`SPIO_SPKT_FLTS);

  // --------------------
  // frame FSM, flags are one-cycle pulses
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state_q  <= st_idle;
      cnt_q    <= '0;
      pkt_long <= 1'b0;
      pkt_done <= 1'b0;
      flt_err  <= 1'b0;
      frm_err  <= 1'b0;
    end else begin
      pkt_done <= 1'b0;
      flt_err  <= 1'b0;
      frm_err  <= 1'b0;
      case (state_q)
        st_idle: begin
          if (is_data) begin
            state_q  <= st_recv;
            cnt_q    <= 5'd1;
            pkt_long <= flit.nib[1];  // header bit 1 marks payload present
          end else if (is_eop) begin
            frm_err <= 1'b1;  // eop with no packet open
          end else if (is_bad) begin
            flt_err <= 1'b1;
            state_q <= st_drop;
          end
        end
        st_recv: begin
          if (is_data) begin
            if (cnt_q != '1) cnt_q <= cnt_q + 5'd1;  // hold at max on runaway
          end else if (is_eop) begin
            if (cnt_q == exp_cnt) begin
              pkt_done <= 1'b1;
            end else begin
              frm_err <= 1'b1;  // short or long frame
            end
            state_q <= st_idle;
          end else if (is_bad) begin
            flt_err <= 1'b1;
            state_q <= st_drop;
          end
        end
        st_drop: begin
          if (is_eop) state_q <= st_idle;  // resync on next eop
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  a_done_xor_frm : assert property (
    @(posedge CLK_IN) disable iff (RESET_IN)
    !(pkt_done && frm_err)
  ) else $error("packet completed and framing error together");

endmodule

// ==== spio_link_receiver.sv ====
`include "spio_cfg.svh"

module spio_link_receiver (
  input  logic                      CLK_IN,
  input  logic                      RESET_IN,
  // spinnaker link side
  input  logic [`SPIO_SYM_BITS-1:0] link_data,
  output logic                      link_ack,
  // packet side
  output logic [`SPIO_PKT_BITS-1:0] pkt_data,
  output logic                      pkt_vld,
  input  logic                      pkt_rdy,
  // error pulses
  output logic                      flt_err,
  output logic                      frm_err
);

  logic                      pkt_done;    // good eop seen
  logic                      pkt_long;
  logic                      accept_rdy;  // output stage free
  logic [`SPIO_PKT_BITS-1:0] pkt_buf;

  spio_flit_if flit_bus ();

  assign flit_bus.rdy = accept_rdy;

  // --------------------
  spio_flit_capture u_capture (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .link_data (link_data),
    .link_ack  (link_ack),
    .flit      (flit_bus.src)
  );

  spio_frame_checker u_checker (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flit     (flit_bus.sink_ctl),
    .pkt_done (pkt_done),
    .pkt_long (pkt_long),
    .flt_err  (flt_err),
    .frm_err  (frm_err)
  );

  spio_pkt_shifter u_shifter (
    .CLK_IN  (CLK_IN),
    .flit    (flit_bus.sink_dat),
    .pkt_buf (pkt_buf)
  );

  spio_pkt_out u_pkt_out (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .pkt_done   (pkt_done),
    .pkt_long   (pkt_long),
    .pkt_buf    (pkt_buf),
    .pkt_data   (pkt_data),
    .pkt_vld    (pkt_vld),
    .pkt_rdy    (pkt_rdy),
    .accept_rdy (accept_rdy)
  );

endmodule

// ==== spio_pkg.sv ====
`include "spio_cfg.svh"

package spio_pkg;

  // --------------------
  // symbol and packet types
  typedef logic [`SPIO_SYM_BITS-1:0] code_t;  // one 2-of-7 word
  typedef logic [`SPIO_NIB_BITS-1:0] nib_t;
  typedef logic [`SPIO_PKT_BITS-1:0] pkt_t;
  typedef logic [4:0]                flit_cnt_t;  // up to 18 data flits

  typedef enum logic [1:0] {
    sym_data,  // one of the sixteen nibble codes
    sym_eop,   // end of packet
    sym_bad    // two or more wires, not a legal code
  } sym_kind_t;

  localparam code_t eop_code = 7'b1100000;

  // two transitions or more means the sender has presented a symbol
  function automatic logic is_new_sym(code_t code);
    return $countones(code) >= 2;
  endfunction

  // --------------------
  // 2-of-7 code table, nibble to rtz code
  function automatic code_t encode(nib_t nib);
    code_t code;
    case (nib)
      4'h0: code = 7'b0010001;
      4'h1: code = 7'b0010010;
      4'h2: code = 7'b0010100;
      4'h3: code = 7'b0011000;
      4'h4: code = 7'b0100001;
      4'h5: code = 7'b0100010;
      4'h6: code = 7'b0100100;
      4'h7: code = 7'b0101000;
      4'h8: code = 7'b1000001;
      4'h9: code = 7'b1000010;
      4'ha: code = 7'b1000100;
      4'hb: code = 7'b1001000;
      4'hc: code = 7'b0000011;
      4'hd: code = 7'b0000110;
      4'he: code = 7'b0001100;
      4'hf: code = 7'b0001001;
      default: code = eop_code;
    endcase
    return code;
  endfunction

  // reverse lookup, zero for eop or bad codes
  function automatic nib_t decode(code_t code);
    nib_t nib;
    nib = '0;
    for (int i = 0; i < 2**`SPIO_NIB_BITS; i++) begin
      if (encode(nib_t'(i)) == code) nib = nib_t'(i);
    end
    return nib;
  endfunction

  function automatic sym_kind_t classify(code_t code);
    sym_kind_t kind;
    kind = sym_bad;  // anything unmatched
    if (code == eop_code) kind = sym_eop;
    for (int i = 0; i < 2**`SPIO_NIB_BITS; i++) begin
      if (encode(nib_t'(i)) == code) kind = sym_data;
    end
    return kind;
  endfunction

endpackage

// ==== spio_pkt_out.sv ====
`include "spio_cfg.svh"

module spio_pkt_out (
  input  logic           CLK_IN,
  input  logic           RESET_IN,
  input  logic           pkt_done,
  input  logic           pkt_long,
  input  spio_pkg::pkt_t pkt_buf,
  output spio_pkg::pkt_t pkt_data,
  output logic           pkt_vld,
  input  logic           pkt_rdy,
  output logic           accept_rdy
);

  logic busy;  // packet held, not yet taken

  assign busy       = pkt_vld && !pkt_rdy;
  assign accept_rdy = !busy;  // stall the link while a packet waits

  // --------------------
  // output register
  always_ff @(posedge CLK_IN) begin
    if (pkt_done) begin
      if (pkt_long) begin
        pkt_data <= pkt_buf;
      end else begin
        pkt_data <= pkt_buf >> `SPIO_SHORT_SHIFT;  // drop the empty payload slot
      end
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_vld <= 1'b0;
    end else if (pkt_done) begin
      pkt_vld <= 1'b1;  // also covers taken-and-reloaded
    end else if (pkt_rdy) begin
      pkt_vld <= 1'b0;
    end
  end

  // back-pressure upstream must keep a second packet from completing
  a_done_not_busy : assert property (
    @(posedge CLK_IN) disable iff (RESET_IN)
    pkt_done |-> !busy
  ) else $error("packet completed while output busy");

endmodule

// ==== spio_pkt_shifter.sv ====
`include "spio_cfg.svh"

module spio_pkt_shifter (
  input  logic           CLK_IN,
  spio_flit_if.sink_dat  flit,
  output spio_pkg::pkt_t pkt_buf
);

  logic shift_en;  // accepted data symbol

  // --------------------
  // nibble assembly
  //
  // newest nibble enters at the top, so after the last flit
  // the header nibble ends up lowest
  // short packets leave it 32 bits up, fixed by the output stage

  assign shift_en = flit.vld && (flit.kind == spio_pkg::sym_data);

  always_ff @(posedge CLK_IN) begin
    if (shift_en) begin
      pkt_buf <= {flit.nib, pkt_buf[`SPIO_PKT_BITS-1:`SPIO_NIB_BITS]};
    end
  end

endmodule

// ==== tb_spio_link_receiver.sv ====
`include "spio_cfg.svh"

module tb_spio_link_receiver;

  // about 33 packets of under 100 cycles each, with wide margin
  localparam int cycle_limit = 20000;
  localparam spio_pkg::code_t eop_rtz = 7'b1100000;
  localparam spio_pkg::code_t bad_rtz = 7'b0000111;  // three wires, never legal

  logic                      CLK_IN = 1'b0;
  logic                      RESET_IN;
  logic [`SPIO_SYM_BITS-1:0] link_data;  // nrz level on the wires
  logic                      link_ack;
  logic [`SPIO_PKT_BITS-1:0] pkt_data;
  logic                      pkt_vld;
  logic                      pkt_rdy;
  logic                      flt_err;
  logic                      frm_err;

  // --------------------
  // scoreboard state
  spio_pkg::pkt_t exp_q [$];                    // packets in send order
  spio_pkg::pkt_t exp_pkt;
  spio_pkg::nib_t nib_buf [`SPIO_LPKT_FLTS];    // payload of the packet being sent
  int             pkt_len;                      // data flits in that packet
  int             sent_cnt    = 0;
  int             pkt_cnt     = 0;              // transfers seen on the output
  int             ack_toggles = 0;
  int             flt_seen    = 0;
  int             frm_seen    = 0;
  int             cycle_cnt   = 0;
  int             err_data    = 0;
  int             err_count   = 0;
  int             err_proto   = 0;
  string          test_name   = "reset";
  logic [31:0]    rng         = 32'd68;         // xorshift state
  logic           ack_ref;                      // ack level before the last drive
  logic           ack_q       = 1'b0;

  spio_link_receiver u_spio_link_receiver (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .link_data (link_data),
    .link_ack  (link_ack),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .flt_err   (flt_err),
    .frm_err   (frm_err)
  );

  always #5 CLK_IN = ~CLK_IN;

  // --------------------
  // event counters and run limit
  always @(posedge CLK_IN) begin
    ack_q     <= link_ack;
    cycle_cnt <= cycle_cnt + 1;
    if (!RESET_IN) begin
      if (link_ack != ack_q) ack_toggles <= ack_toggles + 1;
      if (flt_err) flt_seen <= flt_seen + 1;
      if (frm_err) frm_seen <= frm_seen + 1;
    end
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, run still busy after %0d cycles", cycle_limit);
      $display("errors: data %0d count %0d protocol %0d", err_data, err_count, err_proto);
      $display("Simulation failed");
      $finish;
    end
  end

  // output transfers, compared in order
  always @(posedge CLK_IN) begin
    if (!RESET_IN && pkt_vld && pkt_rdy) begin
      if (exp_q.size() == 0) begin
        err_data++;
        $display("%s: packet delivered when none was expected", test_name);
      end else begin
        exp_pkt = exp_q.pop_front();
        pkt_cnt <= pkt_cnt + 1;
        a_pkt_data : assert (pkt_data == exp_pkt) else begin
          err_data++;
          $display("ERROR %s pkt_data expected %h actual %h", test_name, exp_pkt, pkt_data);
        end
      end
    end
  end

  // stalled output holds its packet and the link gets no ack
  a_stall_hold : assert property (
    @(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_vld && !pkt_rdy) |=> (pkt_vld && $stable(pkt_data) && $stable(link_ack))
  ) else begin
    err_proto++;
    $display("%s: packet or link_ack moved while output stalled", test_name);
  end

  // --------------------
  // helpers
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // first nibble lowest, unused top bits zero
  function automatic spio_pkg::pkt_t pack_nibbles(input int n);
    spio_pkg::pkt_t p;
    p = '0;
    for (int i = 0; i < n; i++) begin
      p[`SPIO_NIB_BITS*i +: `SPIO_NIB_BITS] = nib_buf[i];
    end
    return p;
  endfunction

  task automatic check_count(input string what, input int exp, input int act);
    a_count : assert (act == exp) else begin
      err_count++;
      $display("ERROR %s %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  // called on a rising edge, two wires flip per symbol
  task automatic drive_code(input spio_pkg::code_t rtz);
    ack_ref = link_ack;
    link_data <= link_data ^ rtz;
  endtask

  task automatic wait_ack;
    @(posedge CLK_IN);
    while (link_ack == ack_ref) begin
      @(posedge CLK_IN);
    end
  endtask

  task automatic send_code(input spio_pkg::code_t rtz);
    drive_code(rtz);
    wait_ack();
  endtask

  // random payload, n_req of 0 lets header bit 1 pick the length
  task automatic make_packet(input int n_req);
    for (int i = 0; i < `SPIO_LPKT_FLTS; i++) begin
      rng        = xorshift(rng);
      nib_buf[i] = rng[3:0];
    end
    if (n_req > 0) pkt_len = n_req;
    else if (nib_buf[0][1]) pkt_len = `SPIO_LPKT_FLTS;
    else pkt_len = `SPIO_SPKT_FLTS;
  endtask

  task automatic send_flits(input int first, input int bad_pos);
    for (int i = first; i < pkt_len; i++) begin
      if (i == bad_pos) send_code(bad_rtz);  // corrupt symbol ahead of flit i
      send_code(spio_pkg::encode(nib_buf[i]));
    end
  endtask

  task automatic finish_packet(input bit deliver);
    if (deliver) begin
      exp_q.push_back(pack_nibbles(pkt_len));
      sent_cnt++;
    end
    send_code(eop_rtz);
  endtask

  task automatic send_packet(input int n_req, input int bad_pos, input bit deliver);
    make_packet(n_req);
    send_flits(0, bad_pos);
    finish_packet(deliver);
  endtask

  task automatic settle;
    repeat (12) @(posedge CLK_IN);
  endtask

  // --------------------
  // stimulus
  initial begin
    RESET_IN  <= 1'b1;
    link_data <= '0;
    pkt_rdy   <= 1'b1;
    repeat (10) @(posedge CLK_IN);
    RESET_IN <= 1'b0;

    repeat (8) @(posedge CLK_IN);  // start-up ack only
    check_count("link_ack toggles", 1, ack_toggles);
    check_count("link_ack level", 1, int'(link_ack));
    check_count("flt_err pulses", 0, flt_seen);
    check_count("frm_err pulses", 0, frm_seen);
    check_count("pkt_vld level", 0, int'(pkt_vld));

    test_name = "random_packets";
    repeat (24) send_packet(0, -1, 1'b1);
    settle();
    check_count("packets delivered", sent_cnt, pkt_cnt);

    // sink stalls, next packet's first flit must wait
    test_name = "backpressure";
    pkt_rdy <= 1'b0;
    send_packet(0, -1, 1'b1);
    for (int k = 0; k < 3; k++) begin
      while (!pkt_vld) begin
        @(posedge CLK_IN);
      end
      make_packet(0);
      drive_code(spio_pkg::encode(nib_buf[0]));
      repeat (12) @(posedge CLK_IN);
      check_count("link_ack level while stalled", int'(ack_ref), int'(link_ack));
      pkt_rdy <= 1'b1;
      wait_ack();
      if (k < 2) pkt_rdy <= 1'b0;  // last round drains freely
      send_flits(1, -1);
      finish_packet(1'b1);
    end
    settle();
    check_count("packets delivered", sent_cnt, pkt_cnt);

    test_name = "bad_symbol";
    send_packet(0, 3, 1'b0);  // dropped
    settle();
    check_count("flt_err pulses", 1, flt_seen);
    send_packet(0, -1, 1'b1);

    test_name = "frame_error";
    send_packet(4, -1, 1'b0);  // eop after four flits
    send_code(eop_rtz);        // eop while idle
    settle();
    check_count("frm_err pulses", 2, frm_seen);
    check_count("flt_err pulses", 1, flt_seen);
    send_packet(0, -1, 1'b1);
    settle();

    test_name = "final";
    check_count("packets delivered", sent_cnt, pkt_cnt);
    check_count("packets still expected", 0, exp_q.size());
    $display("errors: data %0d count %0d protocol %0d", err_data, err_count, err_proto);
    if (err_data + err_count + err_proto == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
